//--- Bender.yml
package:
  name: memSubsys

sources:
  - include_dirs:
      - design
    files:
      - design/memCfgPkg.sv
      - design/memBusPkg.sv
      - design/addrGen.sv
      - design/dpRam.sv
      - design/memUnit.sv
      - design/memSubsys.sv
  - target: test
    files:
      - verif/memSubsys_asserts.sv
      - verif/memSubsysTb.sv

//--- design/addrGen.sv
`timescale 1ns/1ps
`include "mem_defines.svh"

module addrGen
   import memCfgPkg::*;
(
   input  logic               clk,
   input  logic               rst,
   input  logic               run,
   input  portCfg_t           cfg,
   output logic [`ADDR_W-1:0] addr,
   output logic               en,
   output logic               finished
);

   agState_t           state;
   logic [`CNT_W-1:0]  delayCnt;
   logic [`CNT_W-1:0]  perCnt;
   logic [`CNT_W-1:0]  iterCnt;
   logic [`ADDR_W-1:0] rowBase;
   logic               lastPer;
   logic               lastIter;

   assign lastPer  = (perCnt == cfg.period - 1'b1);
   assign lastIter = (iterCnt == cfg.iterations - 1'b1);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state    <= AG_IDLE;
         delayCnt <= '0;
         perCnt   <= '0;
         iterCnt  <= '0;
         rowBase  <= '0;
         addr     <= '0;
      end else if (run) begin
         // restart from the first step
         delayCnt <= cfg.delay - 1'b1;
         perCnt   <= '0;
         iterCnt  <= '0;
         rowBase  <= cfg.start;
         addr     <= cfg.start;
         if (cfg.delay == '0) begin
            state <= AG_RUN;
         end else begin
            state <= AG_DELAY;
         end
      end else begin
         case (state)
            AG_DELAY: begin
               if (delayCnt == '0) begin
                  state <= AG_RUN;
               end else begin
                  delayCnt <= delayCnt - 1'b1;
               end
            end
            AG_RUN: begin
               if (!lastPer) begin
                  perCnt <= perCnt + 1'b1;
                  addr   <= addr + cfg.incr;
               end else begin
                  perCnt <= '0;
                  if (lastIter) begin
                     state <= AG_DONE;
                  end else begin
                     // next row starts one shift further on
                     iterCnt <= iterCnt + 1'b1;
                     rowBase <= rowBase + cfg.shift;
                     addr    <= rowBase + cfg.shift;
                  end
               end
            end
            default: begin
               state <= state;
            end
         endcase
      end
   end

   // only the first duty steps of each period touch the ram
   assign en       = (state == AG_RUN) && (perCnt < cfg.duty);
   assign finished = (state == AG_DONE);

endmodule

//--- design/dpRam.sv
`timescale 1ns/1ps
`include "mem_defines.svh"

module dpRam
   import memBusPkg::*;
(
   input  logic               clk,
   input  ramPort_t           portA,
   input  ramPort_t           portB,
   output logic [`DATA_W-1:0] qA,
   output logic [`DATA_W-1:0] qB
);

   logic [`DATA_W-1:0] mem [0:(1 << `ADDR_W)-1];

   // read-before-write on both ports
   always_ff @(posedge clk) begin
      if (portA.en) begin
         qA <= mem[portA.addr];
         if (portA.we) begin
            mem[portA.addr] <= portA.wdata;
         end
      end
      // port b comes last so it wins an address collision
      if (portB.en) begin
         qB <= mem[portB.addr];
         if (portB.we) begin
            mem[portB.addr] <= portB.wdata;
         end
      end
   end

endmodule

//--- design/memBusPkg.sv
`include "mem_defines.svh"

package memBusPkg;

   // host databus request with a single-cycle valid
   typedef struct packed {
      logic               valid;
      logic               write;
      logic [`ADDR_W-1:0] addr;
      logic [`DATA_W-1:0] wdata;
   } busReq_t;

   typedef struct packed {
      logic               ready;
      logic [`DATA_W-1:0] rdata;
   } busResp_t;

   // drive of one ram port
   typedef struct packed {
      logic               en;
      logic               we;
      logic [`ADDR_W-1:0] addr;
      logic [`DATA_W-1:0] wdata;
   } ramPort_t;

endpackage

//--- design/memCfgPkg.sv
`include "mem_defines.svh"

package memCfgPkg;

   // access pattern of one port held static while a run is active
   typedef struct packed {
      logic [`CNT_W-1:0]  iterations;
      logic [`CNT_W-1:0]  period;
      logic [`CNT_W-1:0]  duty;
      logic [`CNT_W-1:0]  delay;
      // address of step (0, 0)
      logic [`ADDR_W-1:0] start;
      // added once per iteration
      logic [`ADDR_W-1:0] shift;
      // added once per period step
      logic [`ADDR_W-1:0] incr;
      // bit-reverse the generated address
      logic               reverse;
      // stream input carries the address
      logic               ext;
      // stream input is written to the ram
      logic               inWr;
   } portCfg_t;

   // address generator states
   typedef enum logic [1:0] {
      AG_IDLE  = 2'd0,
      AG_DELAY = 2'd1,
      AG_RUN   = 2'd2,
      AG_DONE  = 2'd3
   } agState_t;

endpackage

//--- design/memSubsys.sv
`timescale 1ns/1ps
`include "mem_defines.svh"

module memSubsys
   import memCfgPkg::*;
   import memBusPkg::*;
(
   input  logic               clk,
   input  logic               rst,
   input  logic               run,
   input  portCfg_t           cfgA,
   input  portCfg_t           cfgB,
   input  busReq_t            bus,
   input  logic [`DATA_W-1:0] in0,
   input  logic [`DATA_W-1:0] in1,
   output logic               done,
   output busResp_t           resp,
   output logic [`DATA_W-1:0] out0,
   output logic [`DATA_W-1:0] out1
);

   ramPort_t           ramA;
   ramPort_t           ramB;
   logic [`DATA_W-1:0] qA;
   logic [`DATA_W-1:0] qB;

   memUnit memUnitInst (
      .clk  (clk),
      .rst  (rst),
      .run  (run),
      .cfgA (cfgA),
      .cfgB (cfgB),
      .bus  (bus),
      .resp (resp),
      .in0  (in0),
      .in1  (in1),
      .out0 (out0),
      .out1 (out1),
      .done (done),
      .ramA (ramA),
      .ramB (ramB),
      .qA   (qA),
      .qB   (qB)
   );

   dpRam dpRamInst (
      .clk   (clk),
      .portA (ramA),
      .portB (ramB),
      .qA    (qA),
      .qB    (qB)
   );

endmodule

//--- design/memUnit.sv
`timescale 1ns/1ps
`include "mem_defines.svh"

module memUnit
   import memCfgPkg::*;
   import memBusPkg::*;
(
   input  logic               clk,
   input  logic               rst,
   input  logic               run,
   input  portCfg_t           cfgA,
   input  portCfg_t           cfgB,
   input  busReq_t            bus,
   output busResp_t           resp,
   input  logic [`DATA_W-1:0] in0,
   input  logic [`DATA_W-1:0] in1,
   output logic [`DATA_W-1:0] out0,
   output logic [`DATA_W-1:0] out1,
   output logic               done,
   output ramPort_t           ramA,
   output ramPort_t           ramB,
   input  logic [`DATA_W-1:0] qA,
   input  logic [`DATA_W-1:0] qB
);

   logic [`ADDR_W-1:0]  rawA;
   logic [`ADDR_W-1:0]  rawB;
   logic                enA;
   logic                enB;
   logic                finA;
   logic                finB;
   ramPort_t            nextA;
   ramPort_t            nextB;
   logic [`OUT_LAT-1:0] validPipe;
   logic [`OUT_LAT-1:0] readPipe;
   logic [`OUT_LAT-1:0] donePipe;

   function automatic logic [`ADDR_W-1:0] bitRev(input logic [`ADDR_W-1:0] a);
      logic [`ADDR_W-1:0] r;
      for (int i = 0; i < `ADDR_W; i++) begin
         r[i] = a[`ADDR_W-1-i];
      end
      return r;
   endfunction

   // reversal beats the external address
   function automatic logic [`ADDR_W-1:0] effAddr(input portCfg_t cfg,
                                                  input logic [`ADDR_W-1:0] raw,
                                                  input logic [`DATA_W-1:0] din);
      if (cfg.reverse) begin
         return bitRev(raw);
      end
      if (cfg.ext) begin
         return din[`ADDR_W-1:0];
      end
      return raw;
   endfunction

   addrGen genA (
      .clk      (clk),
      .rst      (rst),
      .run      (run),
      .cfg      (cfgA),
      .addr     (rawA),
      .en       (enA),
      .finished (finA)
   );

   addrGen genB (
      .clk      (clk),
      .rst      (rst),
      .run      (run),
      .cfg      (cfgB),
      .addr     (rawB),
      .en       (enB),
      .finished (finB)
   );

   // bus owns port a whenever it is valid
   always_comb begin
      nextA.en    = bus.valid | enA;
      nextA.we    = bus.valid ? bus.write : (enA & cfgA.inWr & ~cfgA.ext);
      nextA.addr  = bus.valid ? bus.addr : effAddr(cfgA, rawA, in0);
      nextA.wdata = bus.valid ? bus.wdata : in0;
      nextB.en    = enB;
      nextB.we    = enB & cfgB.inWr & ~cfgB.ext;
      nextB.addr  = effAddr(cfgB, rawB, in1);
      nextB.wdata = in1;
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ramA <= '0;
         ramB <= '0;
      end else begin
         ramA <= nextA;
         ramB <= nextB;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         out0 <= '0;
         out1 <= '0;
      end else if (run) begin
         out0 <= '0;
         out1 <= '0;
      end else begin
         out0 <= qA;
         out1 <= qB;
      end
   end

   // bus answer and done follow the same three stages as the streams
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         validPipe <= '0;
         readPipe  <= '0;
         donePipe  <= '0;
      end else begin
         validPipe <= {validPipe[`OUT_LAT-2:0], bus.valid};
         readPipe  <= {readPipe[`OUT_LAT-2:0], bus.valid & ~bus.write};
         if (run) begin
            donePipe <= '0;
         end else begin
            donePipe <= {donePipe[`OUT_LAT-2:0], finA & finB};
         end
      end
   end

   always_comb begin
      resp.ready = validPipe[`OUT_LAT-1];
      resp.rdata = readPipe[`OUT_LAT-1] ? out0 : '0;
   end

   assign done = donePipe[`OUT_LAT-1];

endmodule

//--- design/mem_defines.svh
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// data word and ram geometry for 1024 words
`define DATA_W 32
`define ADDR_W 10

// loop counters and start delay
`define CNT_W 10

// ram input reg, ram read and output reg
`define OUT_LAT 3

`endif

//--- files.f
+incdir+design
design/memCfgPkg.sv
design/memBusPkg.sv
design/addrGen.sv
design/dpRam.sv
design/memUnit.sv
design/memSubsys.sv
verif/memSubsys_asserts.sv
verif/memSubsysTb.sv

//--- verif/memSubsysTb.sv
`timescale 1ns/1ps
`include "mem_defines.svh"

module memSubsysTb
   import memCfgPkg::*;
   import memBusPkg::*;
();

   logic               clk;
   logic               rst;
   logic               run;
   portCfg_t           cfgA;
   portCfg_t           cfgB;
   busReq_t            bus;
   logic [`DATA_W-1:0] in0;
   logic [`DATA_W-1:0] in1;
   logic               done;
   busResp_t           resp;
   logic [`DATA_W-1:0] out0;
   logic [`DATA_W-1:0] out1;

   logic [`DATA_W-1:0] model [0:(1 << `ADDR_W)-1];
   logic [`DATA_W-1:0] exp0 [0:2047];
   logic [`DATA_W-1:0] exp1 [0:2047];
   bit                 has0 [0:2047];
   bit                 has1 [0:2047];
   int                 xPort[$];
   int                 xCycle[$];
   logic [`DATA_W-1:0] xVal[$];
   int                 cycles = 0;
   int                 cycleLimit = 0;
   logic               doneExp = 1'b0;

   memSubsys memSubsys_inst (
      .clk  (clk),
      .rst  (rst),
      .run  (run),
      .cfgA (cfgA),
      .cfgB (cfgB),
      .bus  (bus),
      .in0  (in0),
      .in1  (in1),
      .done (done),
      .resp (resp),
      .out0 (out0),
      .out1 (out1)
   );

   initial clk = 1'b0;
   always #20 clk = ~clk;

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycleLimit > 0 && cycles >= cycleLimit) begin
         $display("timeout after %0d cycles without reaching the end of the stimulus", cycles);
         $display("RESULT: FAIL");
         $fatal(1, "simulation timed out");
      end
   end

   // bound assertions count their failures
   always @(negedge clk) begin
      if (memSubsys_inst.memUnitInst.memUnitAsserts.failCount != 0) begin
         $display("a bound assertion on the memory unit failed");
         $display("RESULT: FAIL");
         $fatal(1, "assertion failure");
      end
   end

   task automatic checkEq(input string name, input logic [31:0] act, input logic [31:0] exp);
      if (act !== exp) begin
         $display("FAIL time=%0t %s actual=%h expected=%h", $time, name, act, exp);
         $display("RESULT: FAIL");
         $fatal(1, "value mismatch");
      end
   endtask

   function automatic logic [`ADDR_W-1:0] reverseBits(input logic [`ADDR_W-1:0] a);
      logic [`ADDR_W-1:0] r;
      for (int k = 0; k < `ADDR_W; k++) begin
         r[k] = a[`ADDR_W-1-k];
      end
      return r;
   endfunction

   // enable and effective address of one port at run cycle t
   function automatic bit portStep(input portCfg_t c, input int t,
                                   input logic [`DATA_W-1:0] din,
                                   output logic [`ADDR_W-1:0] a);
      int                 s;
      int                 i;
      int                 p;
      logic [`ADDR_W-1:0] raw;
      a = '0;
      s = t - int'(c.delay);
      if (s < 0 || s >= int'(c.iterations) * int'(c.period)) begin
         return 1'b0;
      end
      i = s / int'(c.period);
      p = s % int'(c.period);
      raw = int'(c.start) + i * int'(c.shift) + p * int'(c.incr);
      if (c.reverse) begin
         a = reverseBits(raw);
      end else if (c.ext) begin
         a = din[`ADDR_W-1:0];
      end else begin
         a = raw;
      end
      return p < int'(c.duty);
   endfunction

   task automatic busOp(input logic wr, input logic [`ADDR_W-1:0] a,
                        input logic [`DATA_W-1:0] d, output logic [`DATA_W-1:0] rd);
      int k;
      @(negedge clk);
      bus.valid = 1'b1;
      bus.write = wr;
      bus.addr  = a;
      bus.wdata = d;
      k = 0;
      do begin
         @(negedge clk);
         k++;
         if (k == 1) begin
            bus.valid = 1'b0;
         end
         if (!resp.ready) begin
            checkEq("resp.rdata", resp.rdata, '0);
         end
      end while (!resp.ready && k < 8);
      checkEq("resp.ready latency", k, `OUT_LAT);
      rd = resp.rdata;
      if (wr) begin
         model[a] = d;
      end else begin
         checkEq("resp.rdata", rd, model[a]);
      end
   endtask

   task automatic doRun(input logic [`DATA_W-1:0] base0, input logic [`DATA_W-1:0] base1);
      int                 fin;
      logic [`ADDR_W-1:0] aA;
      logic [`ADDR_W-1:0] aB;
      bit                 enA;
      bit                 enB;
      bit                 wA;
      bit                 wB;
      fin = int'(cfgA.delay) + int'(cfgA.iterations) * int'(cfgA.period);
      if (int'(cfgB.delay) + int'(cfgB.iterations) * int'(cfgB.period) > fin) begin
         fin = int'(cfgB.delay) + int'(cfgB.iterations) * int'(cfgB.period);
      end
      if (fin + `OUT_LAT >= 2048) begin
         $display("run is too long for the expectation buffers");
         $display("RESULT: FAIL");
         $fatal(1, "run too long");
      end
      for (int t = 0; t < 2048; t++) begin
         has0[t] = 1'b0;
         has1[t] = 1'b0;
      end
      // reads see the old word, then port a writes, then port b
      for (int t = 0; t < fin; t++) begin
         enA = portStep(cfgA, t, base0 + t, aA);
         enB = portStep(cfgB, t, base1 + t, aB);
         wA = enA && cfgA.inWr && !cfgA.ext;
         wB = enB && cfgB.inWr && !cfgB.ext;
         if (enA && !wA) begin
            exp0[t + `OUT_LAT] = model[aA];
            has0[t + `OUT_LAT] = 1'b1;
         end
         if (enB && !wB) begin
            exp1[t + `OUT_LAT] = model[aB];
            has1[t + `OUT_LAT] = 1'b1;
         end
         if (wA) model[aA] = base0 + t;
         if (wB) model[aB] = base1 + t;
      end
      @(negedge clk);
      checkEq("done", done, doneExp);
      run = 1'b1;
      for (int t = 0; t <= fin + `OUT_LAT; t++) begin
         @(negedge clk);
         run = 1'b0;
         in0 = base0 + t;
         in1 = base1 + t;
         if (t == 0) begin
            checkEq("out0", out0, '0);
            checkEq("out1", out1, '0);
         end
         if (has0[t]) checkEq("out0", out0, exp0[t]);
         if (has1[t]) checkEq("out1", out1, exp1[t]);
         checkEq("done", done, t >= fin + `OUT_LAT);
         for (int j = 0; j < xCycle.size(); j++) begin
            if (xCycle[j] == t) begin
               checkEq(xPort[j] == 0 ? "out0" : "out1", xPort[j] == 0 ? out0 : out1, xVal[j]);
            end
         end
      end
      doneExp = 1'b1;
      xPort.delete();
      xCycle.delete();
      xVal.delete();
   endtask

   initial begin
      int                 fd;
      string              line;
      string              cmd;
      int                 port;
      int                 n[4];
      logic [`ADDR_W-1:0] f[3];
      int                 flag[3];
      logic [`DATA_W-1:0] a;
      logic [`DATA_W-1:0] b;
      logic [`DATA_W-1:0] rd;
      int                 steps;
      void'($urandom(32'hafb18d1c));
      rst  = 1'b1;
      run  = 1'b0;
      cfgA = '0;
      cfgB = '0;
      bus  = '0;
      in0  = '0;
      in1  = '0;
      // first pass sizes the timeout from the runs in the file
      steps = 0;
      fd = $fopen("verif/memSubsys_stim.txt", "r");
      if (fd == 0) begin
         $display("could not open the stimulus file");
         $display("RESULT: FAIL");
         $fatal(1, "missing stimulus");
      end
      while ($fgets(line, fd)) begin
         if (line.len() > 1 && line.substr(0, 0) == "C") begin
            void'($sscanf(line, "%s %d %d %d %d %d", cmd, port, n[0], n[1], n[2], n[3]));
            steps += n[0] * n[1] + n[3];
         end
      end
      $fclose(fd);
      cycleLimit = 4 * steps + 2000;

      repeat (16) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      checkEq("done", done, 1'b0);
      checkEq("resp.ready", resp.ready, 1'b0);
      checkEq("out0", out0, '0);
      checkEq("out1", out1, '0);

      fd = $fopen("verif/memSubsys_stim.txt", "r");
      while ($fgets(line, fd)) begin
         if (line.len() < 2 || line.substr(0, 0) == "#") continue;
         void'($sscanf(line, "%s %h %h", cmd, a, b));
         case (cmd)
            "W": busOp(1'b1, a[`ADDR_W-1:0], b, rd);
            "R": begin
               busOp(1'b0, a[`ADDR_W-1:0], '0, rd);
               checkEq("resp.rdata", rd, b);
            end
            "F": begin
               for (int k = int'(a); k <= int'(b); k++) begin
                  busOp(1'b1, k[`ADDR_W-1:0], $urandom, rd);
               end
            end
            "C": begin
               void'($sscanf(line, "%s %d %d %d %d %d %h %h %h %d %d %d", cmd, port,
                             n[0], n[1], n[2], n[3], f[0], f[1], f[2],
                             flag[0], flag[1], flag[2]));
               @(negedge clk);
               if (port == 0) begin
                  cfgA = {n[0][`CNT_W-1:0], n[1][`CNT_W-1:0], n[2][`CNT_W-1:0],
                          n[3][`CNT_W-1:0], f[0], f[1], f[2],
                          flag[0][0], flag[1][0], flag[2][0]};
               end else begin
                  cfgB = {n[0][`CNT_W-1:0], n[1][`CNT_W-1:0], n[2][`CNT_W-1:0],
                          n[3][`CNT_W-1:0], f[0], f[1], f[2],
                          flag[0][0], flag[1][0], flag[2][0]};
               end
            end
            "X": begin
               void'($sscanf(line, "%s %d %d %h", cmd, port, n[0], b));
               xPort.push_back(port);
               xCycle.push_back(n[0]);
               xVal.push_back(b);
            end
            "G": doRun(a, b);
            default: begin
               $display("unknown command in the stimulus file: %s", line);
               $display("RESULT: FAIL");
               $fatal(1, "bad stimulus");
            end
         endcase
      end
      $fclose(fd);
      if (memSubsys_inst.memUnitInst.memUnitAsserts.failCount == 0) begin
         $display("RESULT: PASS");
         $finish;
      end else begin
         $display("a bound assertion on the memory unit failed");
         $display("RESULT: FAIL");
         $fatal(1, "assertion failure");
      end
   end

endmodule

//--- verif/memSubsys_asserts.sv
`timescale 1ns/1ps

module memSubsysAsserts
   import memCfgPkg::*;
   import memBusPkg::*;
(
   input logic     clk,
   input logic     rst,
   input busReq_t  bus,
   input busResp_t resp,
   input ramPort_t nextA,
   input ramPort_t nextB,
   input agState_t stateA,
   input agState_t stateB
);

   int failCount = 0;

   readyPulse: assert property (@(posedge clk) disable iff (rst)
      resp.ready |=> !resp.ready)
      else begin
         failCount++;
         $error("bus ready lasted two cycles");
      end

   // answer comes exactly three cycles after the request
   readyAfterValid: assert property (@(posedge clk) disable iff (rst)
      bus.valid |-> ##3 resp.ready)
      else begin
         failCount++;
         $error("bus ready missing three cycles after valid");
      end

   idleNoEnable: assert property (@(posedge clk) disable iff (rst)
      (stateA == AG_IDLE && stateB == AG_IDLE && !bus.valid) |-> !nextA.en && !nextB.en)
      else begin
         failCount++;
         $error("ram enabled while idle and no bus request");
      end

endmodule

bind memUnit memSubsysAsserts memUnitAsserts (
   .clk    (clk),
   .rst    (rst),
   .bus    (bus),
   .resp   (resp),
   .nextA  (nextA),
   .nextB  (nextB),
   .stateA (genA.state),
   .stateB (genB.state)
);

//--- verif/memSubsys_stim.txt
# W addr data | R addr expected | F first last | G base0 base1 | X port cycle data
# C port iterations period duty delay start shift incr reverse ext inWr (counts decimal)
F 000 03f
F 3c0 3ff
W 005 12345678
W 006 cafef00d
W 3ff 0badbeef
R 005 12345678
R 006 cafef00d
R 3ff 0badbeef
C 0 3 6 4 3 3fc 010 001 0 0 0
C 1 1 1 0 0 000 000 000 0 0 0
X 0 9 0badbeef
G 00000000 00000000
C 0 1 8 8 0 3f8 000 001 0 0 0
C 1 2 4 3 1 100 020 002 0 0 1
X 0 10 0badbeef
G 00000000 a0000000
R 100 a0000001
R 104 a0000003
R 122 a0000006
R 124 a0000007
C 0 1 16 16 2 000 000 040 1 0 0
C 1 1 10 10 0 000 000 000 0 1 0
X 0 15 12345678
X 0 11 cafef00d
X 1 12 0badbeef
G 00000000 550003f6
C 0 2 3 2 0 200 010 001 0 0 1
C 1 1 4 4 5 3fc 000 001 0 0 0
X 1 11 0badbeef
G b0000000 00000000
R 200 b0000000
R 211 b0000004
